//--- design/gamePkg.sv
// Game package
// Button and index types, round limits, the fixed sequence table,
// the control state encoding and the control/status bundles
package gamePkg;

    typedef logic [3:0] buttonsT;
    typedef logic [3:0] indexT;

    localparam int shortRounds = 4;
    localparam int longRounds  = 16;

    // One-hot LED per entry, shown in order
    localparam buttonsT sequenceTable [16] = '{
        4'b0001, 4'b0010, 4'b0100, 4'b1000,
        4'b0100, 4'b0010, 4'b0001, 4'b0001,
        4'b0010, 4'b0010, 4'b0100, 4'b0100,
        4'b1000, 4'b1000, 4'b0001, 4'b0100
    };

    // Codes appear on the state display
    typedef enum logic [3:0] {
        idle      = 4'h0,
        prepare   = 4'h1,
        showLed   = 4'h2,
        showGap   = 4'h3,
        nextShow  = 4'h4,
        waitPlay  = 4'h5,
        checkPlay = 4'h6,
        nextPlay  = 4'h7,
        nextRound = 4'h8,
        won       = 4'h9,
        lost      = 4'hA
    } stateT;

    typedef struct packed {
        logic clearAddr;
        logic countAddr;
        logic clearRound;
        logic countRound;
        logic clearTimer;
        logic countTimer;
        logic registerLevels;
        logic registerPlay;
        logic showLed;
    } ctrlT;

    typedef struct packed {
        logic playMade;
        logic playCorrect;
        logic addrEqualsRound;
        logic lastRound;
        logic ledDone;
        logic gapDone;
        logic timeout;
    } statusT;

endpackage

//--- design/displayPkg.sv
// Display package
// Seven-segment vector and the value nibble fed to the decoders
package displayPkg;

    // Segments g..a, active low
    typedef logic [6:0] segmentsT;

    // Hex digit to show
    typedef logic [3:0] nibbleT;

endpackage

//--- design/hex7seg.sv
// Hexadecimal to seven-segment decoder with active-low outputs
`timescale 1ns/1ns

module hex7seg (
    input  displayPkg::nibbleT   hexa,
    output displayPkg::segmentsT display
);

    always_comb begin
        case (hexa)
            4'h0:    display = 7'b1000000;
            4'h1:    display = 7'b1111001;
            4'h2:    display = 7'b0100100;
            4'h3:    display = 7'b0110000;
            4'h4:    display = 7'b0011001;
            4'h5:    display = 7'b0010010;
            4'h6:    display = 7'b0000010;
            4'h7:    display = 7'b1111000;
            4'h8:    display = 7'b0000000;
            4'h9:    display = 7'b0010000;
            4'hA:    display = 7'b0001000;
            4'hB:    display = 7'b0000011;
            4'hC:    display = 7'b1000110;
            4'hD:    display = 7'b0100001;
            4'hE:    display = 7'b0000110;
            4'hF:    display = 7'b0001110;
            // Blank on unknown input
            default: display = 7'b1111111;
        endcase
    end

endmodule

//--- design/gameDatapath.sv
// Game datapath
// Address, round and timer counters, synchronous sequence ROM,
// level and play registers, play comparator, LED and buzzer drive
`timescale 1ns/1ns

module gameDatapath #(
    parameter int ledCycles     = 3,
    parameter int gapCycles     = 2,
    parameter int timeoutCycles = 40
) (
    input  logic               clock,
    input  logic               arstN,
    input  gamePkg::buttonsT   botoes,
    input  logic               nivelJogadas,
    input  logic               nivelTempo,
    input  gamePkg::ctrlT      ctrl,
    output gamePkg::statusT    status,
    output gamePkg::buttonsT   leds,
    output logic               pulsoBuzzer,
    output logic               levelJogadas,
    output logic               levelTempo,
    output displayPkg::nibbleT dbContagem,
    output displayPkg::nibbleT dbMemoria,
    output displayPkg::nibbleT dbJogada,
    output displayPkg::nibbleT dbRodada
);

    // One gap plus one LED period per shown entry
    localparam int showCycles = gapCycles + ledCycles;
    localparam int timerMax   = (timeoutCycles > showCycles) ? timeoutCycles : showCycles;
    localparam int timerWidth = $clog2(timerMax + 1);

    gamePkg::indexT        addr;
    gamePkg::indexT        round;
    gamePkg::indexT        roundLimit;
    logic [timerWidth-1:0] timer;
    logic [timerWidth-1:0] timeoutLimit;
    gamePkg::buttonsT      memWord;
    gamePkg::buttonsT      playReg;
    gamePkg::buttonsT      lastButtons;

    // Clear wins over count in every counter
    always_ff @(posedge clock or negedge arstN) begin
        if (!arstN) begin
            addr         <= '0;
            round        <= '0;
            timer        <= '0;
            levelJogadas <= 1'b0;
            levelTempo   <= 1'b0;
            playReg      <= '0;
            lastButtons  <= '0;
        end else begin
            if (ctrl.clearAddr) begin
                addr <= '0;
            end else if (ctrl.countAddr) begin
                addr <= addr + 1'b1;
            end

            if (ctrl.clearRound) begin
                round <= '0;
            end else if (ctrl.countRound) begin
                round <= round + 1'b1;
            end

            if (ctrl.clearTimer) begin
                timer <= '0;
            end else if (ctrl.countTimer) begin
                timer <= timer + 1'b1;
            end

            if (ctrl.registerLevels) begin
                levelJogadas <= nivelJogadas;
                levelTempo   <= nivelTempo;
            end

            if (ctrl.registerPlay) begin
                playReg <= botoes;
            end

            // Previous buttons for press edge
            lastButtons <= botoes;
        end
    end

    // Sequence ROM with one cycle read latency
    always_ff @(posedge clock) begin
        memWord <= gamePkg::sequenceTable[addr];
    end

    assign roundLimit   = levelJogadas ? gamePkg::indexT'(gamePkg::longRounds - 1)
                                       : gamePkg::indexT'(gamePkg::shortRounds - 1);
    assign timeoutLimit = levelTempo ? timerWidth'(timeoutCycles / 2)
                                     : timerWidth'(timeoutCycles);

    // Condition flags for the control unit
    assign status.playMade        = (botoes != '0) && (lastButtons == '0);
    assign status.playCorrect     = playReg == memWord;
    assign status.addrEqualsRound = addr == round;
    assign status.lastRound       = round == roundLimit;
    assign status.gapDone         = timer == timerWidth'(gapCycles - 1);
    assign status.ledDone         = timer == timerWidth'(showCycles - 1);
    assign status.timeout         = timer >= timeoutLimit;

    assign leds        = ctrl.showLed ? memWord : '0;
    assign pulsoBuzzer = ctrl.showLed || (botoes != '0);

    // Debug digits
    assign dbContagem = addr;
    assign dbMemoria  = memWord;
    assign dbJogada   = playReg;
    assign dbRodada   = round;

endmodule

//--- design/gameControl.sv
// Game control unit
// Moore state machine driving the datapath strobes and game outputs
`timescale 1ns/1ns

module gameControl (
    input  logic               clock,
    input  logic               arstN,
    input  logic               iniciar,
    input  gamePkg::statusT    status,
    output gamePkg::ctrlT      ctrl,
    output logic               ganhou,
    output logic               perdeu,
    output logic               pronto,
    output logic               vezJogador,
    output logic               dbTimeout,
    output displayPkg::nibbleT dbEstado
);

    gamePkg::stateT state;
    gamePkg::stateT nextState;
    logic           timedOut;

    always_ff @(posedge clock or negedge arstN) begin
        if (!arstN) begin
            state    <= gamePkg::idle;
            timedOut <= 1'b0;
        end else begin
            state <= nextState;
            // Remember why the wait for a press ended
            if (state == gamePkg::waitPlay) begin
                timedOut <= status.timeout && !status.playMade;
            end
        end
    end

    always_comb begin
        nextState = state;
        case (state)
            gamePkg::idle:      if (iniciar) nextState = gamePkg::prepare;
            gamePkg::prepare:   nextState = gamePkg::showGap;
            gamePkg::showGap:   if (status.gapDone) nextState = gamePkg::showLed;
            gamePkg::showLed: begin
                if (status.ledDone) begin
                    nextState = status.addrEqualsRound ? gamePkg::nextPlay
                                                       : gamePkg::nextShow;
                end
            end
            gamePkg::nextShow:  nextState = gamePkg::showGap;
            gamePkg::nextPlay:  nextState = gamePkg::waitPlay;
            gamePkg::waitPlay: begin
                // A press in the same cycle as the timeout still counts
                if (status.playMade) begin
                    nextState = gamePkg::checkPlay;
                end else if (status.timeout) begin
                    nextState = gamePkg::lost;
                end
            end
            gamePkg::checkPlay: begin
                if (!status.playCorrect) begin
                    nextState = gamePkg::lost;
                end else if (status.addrEqualsRound) begin
                    nextState = status.lastRound ? gamePkg::won : gamePkg::nextRound;
                end else begin
                    nextState = gamePkg::waitPlay;
                end
            end
            gamePkg::nextRound: nextState = gamePkg::showGap;
            gamePkg::won,
            gamePkg::lost:      if (iniciar) nextState = gamePkg::prepare;
            default:            nextState = gamePkg::idle;
        endcase
    end

    // Strobes decoded from the state only
    always_comb begin
        ctrl = '0;
        case (state)
            gamePkg::prepare: begin
                ctrl.clearAddr      = 1'b1;
                ctrl.clearRound     = 1'b1;
                ctrl.clearTimer     = 1'b1;
                ctrl.registerLevels = 1'b1;
            end
            gamePkg::showGap:  ctrl.countTimer = 1'b1;
            gamePkg::showLed: begin
                ctrl.countTimer = 1'b1;
                ctrl.showLed    = 1'b1;
            end
            // Step the address and restart the entry timer
            gamePkg::nextShow,
            gamePkg::checkPlay: begin
                ctrl.countAddr  = 1'b1;
                ctrl.clearTimer = 1'b1;
            end
            gamePkg::nextPlay: begin
                ctrl.clearAddr  = 1'b1;
                ctrl.clearTimer = 1'b1;
            end
            gamePkg::waitPlay: begin
                ctrl.countTimer   = 1'b1;
                ctrl.registerPlay = 1'b1;
            end
            gamePkg::nextRound: begin
                ctrl.countRound = 1'b1;
                ctrl.clearAddr  = 1'b1;
                ctrl.clearTimer = 1'b1;
            end
            default: ctrl = '0;
        endcase
    end

    assign vezJogador = state == gamePkg::waitPlay;
    assign ganhou     = state == gamePkg::won;
    assign perdeu     = state == gamePkg::lost;
    assign pronto     = ganhou || perdeu;
    assign dbTimeout  = perdeu && timedOut;
    assign dbEstado   = displayPkg::nibbleT'(state);

endmodule

//--- design/memoryGame.sv
// Memory game top level
// Datapath, control unit and the five debug hex displays
`timescale 1ns/1ns

module memoryGame #(
    parameter int ledCycles     = 3,
    parameter int gapCycles     = 2,
    parameter int timeoutCycles = 40
) (
    input  logic                 clock,
    input  logic                 arstN,
    input  logic                 iniciar,
    input  gamePkg::buttonsT     botoes,
    input  logic                 nivelJogadas,
    input  logic                 nivelTempo,
    output logic                 ganhou,
    output logic                 perdeu,
    output logic                 pronto,
    output logic                 vezJogador,
    output gamePkg::buttonsT     leds,
    output logic                 pulsoBuzzer,
    output displayPkg::segmentsT dbRodada,
    output displayPkg::segmentsT dbContagem,
    output displayPkg::segmentsT dbMemoria,
    output displayPkg::segmentsT dbJogada,
    output displayPkg::segmentsT dbEstado,
    output logic                 dbTimeout
);

    gamePkg::ctrlT      ctrl;
    gamePkg::statusT    status;
    // Values behind the displays
    displayPkg::nibbleT rodadaHex;
    displayPkg::nibbleT contagemHex;
    displayPkg::nibbleT memoriaHex;
    displayPkg::nibbleT jogadaHex;
    displayPkg::nibbleT estadoHex;

    gameDatapath #(
        .ledCycles     ( ledCycles     ),
        .gapCycles     ( gapCycles     ),
        .timeoutCycles ( timeoutCycles )
    ) datapath_i (
        .clock        ( clock        ),
        .arstN        ( arstN        ),
        .botoes       ( botoes       ),
        .nivelJogadas ( nivelJogadas ),
        .nivelTempo   ( nivelTempo   ),
        .ctrl         ( ctrl         ),
        .status       ( status       ),
        .leds         ( leds         ),
        .pulsoBuzzer  ( pulsoBuzzer  ),
        .levelJogadas (              ),
        .levelTempo   (              ),
        .dbContagem   ( contagemHex  ),
        .dbMemoria    ( memoriaHex   ),
        .dbJogada     ( jogadaHex    ),
        .dbRodada     ( rodadaHex    )
    );

    gameControl control_i (
        .clock      ( clock      ),
        .arstN      ( arstN      ),
        .iniciar    ( iniciar    ),
        .status     ( status     ),
        .ctrl       ( ctrl       ),
        .ganhou     ( ganhou     ),
        .perdeu     ( perdeu     ),
        .pronto     ( pronto     ),
        .vezJogador ( vezJogador ),
        .dbTimeout  ( dbTimeout  ),
        .dbEstado   ( estadoHex  )
    );

    hex7seg rodadaDisplay_i   ( .hexa ( rodadaHex   ), .display ( dbRodada   ) );
    hex7seg contagemDisplay_i ( .hexa ( contagemHex ), .display ( dbContagem ) );
    hex7seg memoriaDisplay_i  ( .hexa ( memoriaHex  ), .display ( dbMemoria  ) );
    hex7seg jogadaDisplay_i   ( .hexa ( jogadaHex   ), .display ( dbJogada   ) );
    hex7seg estadoDisplay_i   ( .hexa ( estadoHex   ), .display ( dbEstado   ) );

endmodule

//--- sim/memoryGame_chk.sv
// Concurrent assertions on the game outputs
// Bound into the memory game top level
`timescale 1ns/1ns

module memoryGameChk (
    input logic             clock,
    input logic             arstN,
    input logic             ganhou,
    input logic             perdeu,
    input logic             pronto,
    input logic             vezJogador,
    input gamePkg::buttonsT leds
);

    // Number of assertion failures so far
    int failCount = 0;

    resultExclusive: assert property (@(posedge clock) disable iff (!arstN)
        !(ganhou && perdeu))
        else begin
            failCount++;
            $error("ganhou and perdeu are high together");
        end

    ledsOneHot: assert property (@(posedge clock) disable iff (!arstN)
        $onehot0(leds))
        else begin
            failCount++;
            $error("leds is neither zero nor one-hot");
        end

    // Sequence display and player turn never overlap
    turnWithoutLeds: assert property (@(posedge clock) disable iff (!arstN)
        !(vezJogador && (leds != '0)))
        else begin
            failCount++;
            $error("vezJogador is high while an LED is lit");
        end

    prontoHasResult: assert property (@(posedge clock) disable iff (!arstN)
        pronto |-> (ganhou || perdeu))
        else begin
            failCount++;
            $error("pronto is high without ganhou or perdeu");
        end

endmodule

//--- sim/memoryGameMonitor.sv
// Memory game monitor
// Watches the DUT ports, compares them with the expected game and counts errors
`timescale 1ns/1ns

module memoryGameMonitor #(
    parameter int ledCycles     = 3,
    parameter int timeoutCycles = 40
) (
    input  logic                 clock,
    input  logic                 arstN,
    input  logic                 iniciar,
    input  gamePkg::buttonsT     botoes,
    input  logic                 nivelTempo,
    input  logic                 ganhou,
    input  logic                 perdeu,
    input  logic                 pronto,
    input  logic                 vezJogador,
    input  gamePkg::buttonsT     leds,
    input  logic                 pulsoBuzzer,
    input  logic                 dbTimeout,
    input  displayPkg::segmentsT dbRodada,
    input  displayPkg::segmentsT dbContagem,
    input  displayPkg::segmentsT dbMemoria,
    input  displayPkg::segmentsT dbJogada,
    input  displayPkg::segmentsT dbEstado,
    input  logic                 expGanhou,
    input  logic                 expPerdeu,
    input  logic                 expTimeout,
    input  int                   expRound,
    output int                   errorCount,
    output int                   checkCount
);

    // Lit segments g..a for the digits 0 to F
    localparam logic [6:0] litSegments [16] = '{
        7'h3F, 7'h06, 7'h5B, 7'h4F, 7'h66, 7'h6D, 7'h7D, 7'h07,
        7'h7F, 7'h6F, 7'h77, 7'h7C, 7'h39, 7'h5E, 7'h79, 7'h71
    };

    logic             started;
    logic             gameOver;
    logic             prevVez;
    logic             prevPronto;
    logic             pressSeen;
    gamePkg::buttonsT prevLeds;
    gamePkg::buttonsT prevBotoes;
    gamePkg::buttonsT pressedButton;
    int               cycle = 0;
    int               pulseCount;
    int               ledRun;
    int               currentRound;
    int               vezRiseCycle;

    initial begin
        errorCount = 0;
        checkCount = 0;
    end

    task automatic checkThat(input logic ok, input string msg);
        checkCount++;
        if (ok !== 1'b1) begin
            errorCount++;
            $display("error at %0t ns: %s", $time, msg);
        end
    endtask

    // Result, round reached and cause of a loss
    task automatic verifyGameEnd();
        int limit;
        int waited;
        limit  = nivelTempo ? timeoutCycles / 2 : timeoutCycles;
        waited = cycle - vezRiseCycle;
        checkThat(ganhou == expGanhou && perdeu == expPerdeu,
            $sformatf("game ended with ganhou %b and perdeu %b", ganhou, perdeu));
        checkThat(currentRound == expRound,
            $sformatf("game ended in round %0d, expected %0d", currentRound, expRound));
        checkThat(dbRodada == ~litSegments[expRound - 1],
            $sformatf("dbRodada shows %b at the end of the game", dbRodada));
        checkThat(dbEstado == ~litSegments[expGanhou ? gamePkg::won : gamePkg::lost],
            $sformatf("dbEstado shows %b at the end of the game", dbEstado));
        if (perdeu) begin
            checkThat(dbTimeout == expTimeout, "dbTimeout does not match the cause of the loss");
        end
        if (expTimeout) begin
            checkThat(waited >= limit && waited <= limit + 3,
                $sformatf("timeout came %0d cycles after vezJogador rose", waited));
        end
    endtask

    // Samples before the DUT registers update
    always @(posedge clock) begin
        cycle++;
        if (!arstN) begin
            started       = 1'b0;
            gameOver      = 1'b0;
            prevVez       = 1'b0;
            prevPronto    = 1'b0;
            pressSeen     = 1'b0;
            prevLeds      = '0;
            prevBotoes    = '0;
            pressedButton = '0;
            pulseCount    = 0;
            ledRun        = 0;
            currentRound  = 0;
        end else begin
            checkThat(pulsoBuzzer == ((leds != '0) || (botoes != '0)),
                "pulsoBuzzer does not follow leds and botoes");
            if (!started) begin
                checkThat({ganhou, perdeu, pronto, vezJogador, leds} == '0,
                    "outputs are active before the first game");
                checkThat(dbEstado == ~litSegments[gamePkg::idle],
                    "dbEstado does not show idle before the first game");
            end
            if (gameOver) begin
                checkThat(pronto, "pronto dropped before the next iniciar");
            end
            if (iniciar) begin
                started      = 1'b1;
                gameOver     = 1'b0;
                pulseCount   = 0;
                currentRound = 0;
            end
            // The play register shows a press one cycle after its edge
            if (pressSeen) begin
                checkThat(dbJogada == ~litSegments[pressedButton],
                    $sformatf("dbJogada shows %b after a press of %b", dbJogada, pressedButton));
            end
            pressSeen = vezJogador && (botoes != '0) && (prevBotoes == '0);
            if (pressSeen) begin
                pressedButton = botoes;
            end
            // First pulse after a player turn opens a new round
            if (leds != '0) begin
                if (prevLeds == '0) begin
                    if (pulseCount == 0) begin
                        currentRound++;
                    end
                    pulseCount++;
                    ledRun = 0;
                    checkThat(pulseCount <= 16 && leds == gamePkg::sequenceTable[pulseCount - 1],
                        $sformatf("pulse %0d shows leds %b", pulseCount, leds));
                end else begin
                    checkThat(leds == prevLeds, "leds changed within one pulse");
                end
                checkThat(dbMemoria == ~litSegments[leds],
                    $sformatf("dbMemoria shows %b while leds is %b", dbMemoria, leds));
                checkThat(dbContagem == ~litSegments[pulseCount - 1],
                    $sformatf("dbContagem shows %b during pulse %0d", dbContagem, pulseCount));
                ledRun++;
            end else if (prevLeds != '0) begin
                checkThat(ledRun == ledCycles, $sformatf("LED pulse lasted %0d cycles", ledRun));
            end
            if (vezJogador && !prevVez) begin
                if (pulseCount != 0) begin
                    checkThat(pulseCount == currentRound,
                        $sformatf("round %0d showed %0d pulses", currentRound, pulseCount));
                    pulseCount = 0;
                end
                vezRiseCycle = cycle;
            end
            if (pronto && !prevPronto) begin
                verifyGameEnd();
                gameOver = 1'b1;
            end
            prevLeds   = leds;
            prevBotoes = botoes;
            prevVez    = vezJogador;
            prevPronto = pronto;
        end
    end

endmodule

//--- sim/memoryGameTb.sv
// Memory game testbench
// Clock, reset, stimulus table, player model and run timeout
`timescale 1ns/1ns

module memoryGameTb;

    localparam int ledCycles     = 3;
    localparam int gapCycles     = 2;
    localparam int timeoutCycles = 40;
    localparam int rowCount      = 6;

    typedef enum logic [1:0] {
        noFailure,
        wrongButton,
        noPress
    } failureT;

    typedef struct packed {
        logic       nivelJogadas;
        logic       nivelTempo;
        logic [4:0] failRound;
        failureT    failure;
        logic       expGanhou;
        logic       expPerdeu;
    } rowT;

    // Levels, failing round (0 for none), failure kind, expected ganhou and perdeu
    localparam rowT stimTable [rowCount] = '{
        '{1'b0, 1'b0, 5'd0, noFailure,   1'b1, 1'b0},
        '{1'b0, 1'b1, 5'd3, wrongButton, 1'b0, 1'b1},
        '{1'b0, 1'b0, 5'd2, noPress,     1'b0, 1'b1},
        '{1'b0, 1'b1, 5'd1, noPress,     1'b0, 1'b1},
        '{1'b1, 1'b0, 5'd0, noFailure,   1'b1, 1'b0},
        '{1'b1, 1'b1, 5'd6, wrongButton, 1'b0, 1'b1}
    };

    logic                 clock;
    logic                 arstN;
    logic                 iniciar;
    gamePkg::buttonsT     botoes;
    logic                 nivelJogadas;
    logic                 nivelTempo;
    logic                 ganhou;
    logic                 perdeu;
    logic                 pronto;
    logic                 vezJogador;
    gamePkg::buttonsT     leds;
    logic                 pulsoBuzzer;
    displayPkg::segmentsT dbRodada;
    displayPkg::segmentsT dbContagem;
    displayPkg::segmentsT dbMemoria;
    displayPkg::segmentsT dbJogada;
    displayPkg::segmentsT dbEstado;
    logic                 dbTimeout;
    logic                 expGanhou;
    logic                 expPerdeu;
    logic                 expTimeout;
    int                   expRound;
    int                   errorCount;
    int                   checkCount;
    int                   cycleCount = 0;
    int                   cycleLimit;

    initial clock = 1'b0;
    always #10 clock = ~clock;

    memoryGame #(
        .ledCycles     ( ledCycles     ),
        .gapCycles     ( gapCycles     ),
        .timeoutCycles ( timeoutCycles )
    ) dut_i (
        .clock        ( clock        ),
        .arstN        ( arstN        ),
        .iniciar      ( iniciar      ),
        .botoes       ( botoes       ),
        .nivelJogadas ( nivelJogadas ),
        .nivelTempo   ( nivelTempo   ),
        .ganhou       ( ganhou       ),
        .perdeu       ( perdeu       ),
        .pronto       ( pronto       ),
        .vezJogador   ( vezJogador   ),
        .leds         ( leds         ),
        .pulsoBuzzer  ( pulsoBuzzer  ),
        .dbRodada     ( dbRodada     ),
        .dbContagem   ( dbContagem   ),
        .dbMemoria    ( dbMemoria    ),
        .dbJogada     ( dbJogada     ),
        .dbEstado     ( dbEstado     ),
        .dbTimeout    ( dbTimeout    )
    );

    memoryGameMonitor #(
        .ledCycles     ( ledCycles     ),
        .timeoutCycles ( timeoutCycles )
    ) monitor_i (
        .clock       ( clock       ),
        .arstN       ( arstN       ),
        .iniciar     ( iniciar     ),
        .botoes      ( botoes      ),
        .nivelTempo  ( nivelTempo  ),
        .ganhou      ( ganhou      ),
        .perdeu      ( perdeu      ),
        .pronto      ( pronto      ),
        .vezJogador  ( vezJogador  ),
        .leds        ( leds        ),
        .pulsoBuzzer ( pulsoBuzzer ),
        .dbTimeout   ( dbTimeout   ),
        .dbRodada    ( dbRodada    ),
        .dbContagem  ( dbContagem  ),
        .dbMemoria   ( dbMemoria   ),
        .dbJogada    ( dbJogada    ),
        .dbEstado    ( dbEstado    ),
        .expGanhou   ( expGanhou   ),
        .expPerdeu   ( expPerdeu   ),
        .expTimeout  ( expTimeout  ),
        .expRound    ( expRound    ),
        .errorCount  ( errorCount  ),
        .checkCount  ( checkCount  )
    );

    bind memoryGame memoryGameChk chk_i (
        .clock      ( clock      ),
        .arstN      ( arstN      ),
        .ganhou     ( ganhou     ),
        .perdeu     ( perdeu     ),
        .pronto     ( pronto     ),
        .vezJogador ( vezJogador ),
        .leds       ( leds       )
    );

    // Worst case per row is every round shown in full plus a timeout
    function automatic int limitFromTable();
        int total;
        int rounds;
        total = 20;
        for (int row = 0; row < rowCount; row++) begin
            rounds = stimTable[row].nivelJogadas ? gamePkg::longRounds : gamePkg::shortRounds;
            total += rounds * (rounds * (ledCycles + gapCycles + 4) + timeoutCycles);
        end
        return total;
    endfunction

    function automatic gamePkg::buttonsT otherButton(input gamePkg::buttonsT expected);
        gamePkg::buttonsT pick;
        pick = expected;
        while (pick == expected) begin
            pick = gamePkg::buttonsT'(4'b0001 << ($urandom % 4));
        end
        return pick;
    endfunction

    // Hold for two cycles and release for one so the next press has an edge
    task automatic pressButton(input gamePkg::buttonsT button);
        botoes = button;
        repeat (2) @(negedge clock);
        botoes = '0;
        @(negedge clock);
    endtask

    task automatic playRow(input rowT row);
        int rounds;
        if (row.failRound != 0) begin
            rounds = row.failRound;
        end else begin
            rounds = row.nivelJogadas ? gamePkg::longRounds : gamePkg::shortRounds;
        end
        nivelJogadas = row.nivelJogadas;
        nivelTempo   = row.nivelTempo;
        expGanhou    = row.expGanhou;
        expPerdeu    = row.expPerdeu;
        expTimeout   = row.failure == noPress;
        expRound     = rounds;
        iniciar = 1'b1;
        @(negedge clock);
        iniciar = 1'b0;
        for (int round = 1; round <= rounds; round++) begin
            for (int k = 0; k < round; k++) begin
                // Presses only count during the player's turn
                while (!vezJogador) @(negedge clock);
                if (round != row.failRound || k != round - 1) begin
                    pressButton(gamePkg::sequenceTable[k]);
                end else if (row.failure == wrongButton) begin
                    pressButton(otherButton(gamePkg::sequenceTable[k]));
                end
            end
        end
        while (!pronto) @(negedge clock);
        repeat (2) @(negedge clock);
    endtask

    always @(posedge clock) begin
        cycleCount++;
        if (cycleCount >= cycleLimit) begin
            $display("run stopped after %0d cycles before all games ended", cycleCount);
            $display("test failed");
            $finish;
        end
    end

    initial begin
        void'($urandom(32'h2620));
        cycleLimit   = limitFromTable();
        arstN        = 1'b0;
        iniciar      = 1'b0;
        botoes       = '0;
        nivelJogadas = 1'b0;
        nivelTempo   = 1'b0;
        expGanhou    = 1'b0;
        expPerdeu    = 1'b0;
        expTimeout   = 1'b0;
        expRound     = 1;
        repeat (3) @(negedge clock);
        arstN = 1'b1;
        // Idle cycles before the first game
        repeat (4) @(negedge clock);
        for (int row = 0; row < rowCount; row++) begin
            playRow(stimTable[row]);
        end
        $display("%0d checks, %0d monitor errors, %0d assertion failures",
            checkCount, errorCount, dut_i.chk_i.failCount);
        if (errorCount == 0 && dut_i.chk_i.failCount == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

//--- compile.f
design/gamePkg.sv
design/displayPkg.sv
design/hex7seg.sv
design/gameDatapath.sv
design/gameControl.sv
design/memoryGame.sv
sim/memoryGame_chk.sv
sim/memoryGameMonitor.sv
sim/memoryGameTb.sv

//--- Bender.yml
package:
  name: memory_game

sources:
  - design/gamePkg.sv
  - design/displayPkg.sv
  - design/hex7seg.sv
  - design/gameDatapath.sv
  - design/gameControl.sv
  - design/memoryGame.sv
  - target: simulation
    files:
      - sim/memoryGame_chk.sv
      - sim/memoryGameMonitor.sv
      - sim/memoryGameTb.sv
